/* all.f */
design/gemm_pkg.sv
design/operand_skew.sv
design/mac_cell.sv
design/mac_array.sv
design/psum_deskew.sv
design/result_accumulator.sv
design/gemm_datapath.sv
tb/gemm_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= gemm_tb
FILELIST ?= all.f
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/gemm_tb.sv */
module gemm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int total_beats = 53;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  gemm_pkg::in_beat_t in_beat;
  logic               in_credit;
  logic               out_valid;
  gemm_pkg::sum_row_t out_row;
  logic               out_credit;

  gemm_pkg::sum_row_t exp_q [$];
  gemm_pkg::sum_row_t acc_model = '0;
  gemm_pkg::wgt_vec_t [gemm_pkg::array_dim-1:0] w_shadow = '0;
  gemm_pkg::wgt_vec_t [gemm_pkg::array_dim-1:0] w_active = '0;
  logic [31:0] lfsr_state = 32'd77944;

  int checks = 0;
  int errors = 0;
  int err_mark = 0;
  int rows_popped = 0;
  int in_credits_seen = 0;
  int lasts_sent = 0;
  int owed = 0;
  int given = 0;
  int hold_left = 0;
  bit bp_random = 1'b0;

  gemm_datapath dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // column c sums a[r] * w[r][c] over all rows in 24 bits
  function automatic gemm_pkg::sum_row_t ref_row(
    input gemm_pkg::sum_row_t prev,
    input gemm_pkg::act_vec_t a,
    input logic acc,
    input gemm_pkg::wgt_vec_t [gemm_pkg::array_dim-1:0] w
  );
    gemm_pkg::sum_row_t res;
    int s;
    for (int c = 0; c < gemm_pkg::array_dim; c++) begin
      s = acc ? $signed(prev[c]) : 0;
      for (int r = 0; r < gemm_pkg::array_dim; r++) begin
        s = s + $signed(a[r]) * $signed(w[r][c]);
      end
      res[c] = gemm_pkg::psum_t'(s);
    end
    return res;
  endfunction

  task automatic send_beat(input gemm_pkg::in_beat_t b);
    if (!b.is_wgt && b.last) begin
      while (gemm_pkg::fifo_depth + in_credits_seen - lasts_sent <= 0) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
      lasts_sent++;
    end
    in_valid <= 1'b1;
    in_beat <= b;
    @(posedge clk);
  endtask

  // first weight beat of a matrix ends up in row 3
  task automatic send_wgt(input logic [31:0] vec, input logic commit);
    gemm_pkg::in_beat_t b;
    b = '0;
    b.is_wgt = 1'b1;
    b.commit = commit;
    b.payload.wgt = vec;
    for (int r = gemm_pkg::array_dim - 1; r > 0; r--) begin
      w_shadow[r] = w_shadow[r-1];
    end
    w_shadow[0] = vec;
    if (commit) begin
      w_active = w_shadow;
    end
    send_beat(b);
  endtask

  task automatic send_act(input logic [31:0] vec, input logic acc, input logic last);
    gemm_pkg::in_beat_t b;
    b = '0;
    b.acc = acc;
    b.last = last;
    b.payload.act = vec;
    acc_model = ref_row(acc_model, b.payload.act, acc, w_active);
    if (last) begin
      exp_q.push_back(acc_model);
    end
    send_beat(b);
  endtask

  task automatic send_matrix();
    for (int k = 0; k < gemm_pkg::array_dim; k++) begin
      send_wgt(take_bits(32), k == gemm_pkg::array_dim - 1);
    end
  endtask

  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      checks += 2;
      assert (out_valid === 1'b0) else begin
        errors++;
        $display("FAIL %0t out_valid expected 0 got %b", $time, out_valid);
      end
      assert (in_credit === 1'b0) else begin
        errors++;
        $display("FAIL %0t in_credit expected 0 got %b", $time, in_credit);
      end
    end
    @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    in_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("test %s done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // compares each popped row and plays the consumer's credit return
  initial begin
    gemm_pkg::sum_row_t exp_row;
    logic grant;
    forever begin
      @(negedge clk);
      grant = 1'b0;
      if (in_credit === 1'b1) begin
        in_credits_seen++;
        checks++;
        assert (in_credits_seen <= rows_popped) else begin
          errors++;
          $display("in_credit pulse at %0t without a popped row", $time);
        end
      end
      if (out_valid === 1'b1) begin
        rows_popped++;
        owed++;
        checks++;
        assert (rows_popped <= gemm_pkg::out_credits + given) else begin
          errors++;
          $display("out_valid at %0t beyond the output credits granted", $time);
        end
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("out_valid at %0t with no row expected", $time);
        end
        if (exp_q.size() != 0) begin
          exp_row = exp_q.pop_front();
          checks++;
          assert (out_row === exp_row) else begin
            errors++;
            $display("FAIL %0t out_row expected %h got %h", $time, exp_row, out_row);
          end
        end
      end
      if (hold_left > 0) begin
        hold_left--;
      end else if (owed > 0) begin
        grant = bp_random ? 1'(take_bits(1)) : 1'b1;
      end
      if (grant) begin
        owed--;
        given++;
      end
      @(posedge clk);
      out_credit <= grant;
    end
  end

  initial begin
    #((total_beats + 40) * 100 * 4);
    $display("timeout at %0t, the run did not finish", $time);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_beat = '0;
    out_credit = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    check_idle(8);
    finish_test("reset state");

    // extremes on the first two weight rows and first three vectors
    send_wgt(32'h80808080, 1'b0);
    send_wgt(32'h7f7f7f7f, 1'b0);
    send_wgt(take_bits(32), 1'b0);
    send_wgt(take_bits(32), 1'b1);
    send_act(32'h80808080, 1'b0, 1'b1);
    send_act(32'h7f7f7f7f, 1'b0, 1'b1);
    send_act(32'h807f807f, 1'b0, 1'b1);
    for (int i = 0; i < 5; i++) begin
      send_act(take_bits(32), 1'b0, 1'b1);
    end
    finish_test("single vectors");

    send_matrix();
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < 4; k++) begin
        send_act(take_bits(32), k != 0, k == 3);
      end
    end
    finish_test("accumulation");

    // shadow shifts between activations and the commit sits between old and new ones
    send_act(take_bits(32), 1'b0, 1'b1);
    send_act(take_bits(32), 1'b0, 1'b1);
    send_wgt(take_bits(32), 1'b0);
    send_wgt(take_bits(32), 1'b0);
    send_wgt(take_bits(32), 1'b0);
    send_act(take_bits(32), 1'b0, 1'b1);
    send_wgt(take_bits(32), 1'b1);
    send_act(take_bits(32), 1'b0, 1'b1);
    send_act(take_bits(32), 1'b0, 1'b1);
    finish_test("weight reload");

    hold_left = 30;
    bp_random = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_act(take_bits(32), 1'b0, 1'b1);
    end
    finish_test("back-pressure");
    bp_random = 1'b0;

    checks++;
    assert (in_credits_seen == rows_popped) else begin
      errors++;
      $display("FAIL %0t in_credit pulses expected %0d got %0d", $time, rows_popped,
               in_credits_seen);
    end
    checks++;
    assert (rows_popped == lasts_sent) else begin
      errors++;
      $display("FAIL %0t rows popped expected %0d got %0d", $time, lasts_sent, rows_popped);
    end
    $display("%0d checks, %0d errors, %0d rows", checks, errors, rows_popped);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* design/gemm_datapath.sv */
module gemm_datapath (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  gemm_pkg::in_beat_t in_beat,
  output logic               in_credit,
  output logic               out_valid,
  output gemm_pkg::sum_row_t out_row,
  input  logic               out_credit
);

  gemm_pkg::act_vec_t             act_row;
  logic [gemm_pkg::array_dim-1:0] act_valid;
  gemm_pkg::wgt_vec_t             wgt_col;
  logic [gemm_pkg::array_dim-1:0] wgt_shift;
  logic [gemm_pkg::array_dim-1:0] wgt_commit;
  gemm_pkg::beat_ctrl_t           ctrl_aligned;
  gemm_pkg::sum_row_t             col_sum;
  logic [gemm_pkg::array_dim-1:0] col_valid;
  gemm_pkg::sum_row_t             row_sum;
  logic                           row_valid;

  operand_skew u_skew (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .act_row     (act_row),
    .act_valid   (act_valid),
    .wgt_col     (wgt_col),
    .wgt_shift   (wgt_shift),
    .wgt_commit  (wgt_commit),
    .ctrl_aligned(ctrl_aligned)
  );

  mac_array u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .act_row   (act_row),
    .act_valid (act_valid),
    .wgt_col   (wgt_col),
    .wgt_shift (wgt_shift),
    .wgt_commit(wgt_commit),
    .col_sum   (col_sum),
    .col_valid (col_valid)
  );

  psum_deskew u_deskew (
    .clk      (clk),
    .rst_n    (rst_n),
    .col_sum  (col_sum),
    .col_valid(col_valid),
    .row_sum  (row_sum),
    .row_valid(row_valid)
  );

  result_accumulator u_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_sum   (row_sum),
    .row_valid (row_valid),
    .ctrl      (ctrl_aligned),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_credit(out_credit)
  );

endmodule

/* design/result_accumulator.sv */
module result_accumulator (
  input  logic                 clk,
  input  logic                 rst_n,
  input  gemm_pkg::sum_row_t   row_sum,
  input  logic                 row_valid,
  input  gemm_pkg::beat_ctrl_t ctrl,
  output logic                 in_credit,
  output logic                 out_valid,
  output gemm_pkg::sum_row_t   out_row,
  input  logic                 out_credit
);

  logic                 upd;
  logic                 push_q;
  logic                 pop;
  gemm_pkg::sum_row_t   acc_row;
  gemm_pkg::sum_row_t   acc_next;
  gemm_pkg::sum_row_t   fifo_mem [gemm_pkg::fifo_depth];
  gemm_pkg::ptr_t       wr_ptr;
  gemm_pkg::ptr_t       rd_ptr;
  gemm_pkg::cnt_t       fifo_cnt;
  gemm_pkg::ocnt_t      out_cnt;

  assign upd = row_valid && ctrl.valid;

  // acc clear starts a new row, acc set adds into it
  always_comb begin
    for (int c = 0; c < gemm_pkg::array_dim; c++) begin
      if (ctrl.acc) begin
        acc_next[c] = acc_row[c] + row_sum[c];
      end else begin
        acc_next[c] = row_sum[c];
      end
    end
  end

  // only send while the consumer has granted room
  assign pop = (fifo_cnt != '0) && (out_cnt != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_row <= '0;
      push_q <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      fifo_cnt <= '0;
      out_cnt <= gemm_pkg::ocnt_t'(gemm_pkg::out_credits);
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      if (upd) begin
        acc_row <= acc_next;
      end
      push_q <= upd && ctrl.last;
      if (push_q) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + gemm_pkg::cnt_t'(push_q) - gemm_pkg::cnt_t'(pop);
      out_cnt <= out_cnt + gemm_pkg::ocnt_t'(out_credit) - gemm_pkg::ocnt_t'(pop);
      out_valid <= pop;
      // slot is free again, tell upstream a cycle after the pop
      in_credit <= out_valid;
    end
  end

  // finished row enters the fifo the cycle after its last update
  always_ff @(posedge clk) begin
    if (push_q) begin
      fifo_mem[wr_ptr] <= acc_row;
    end
    if (pop) begin
      out_row <= fifo_mem[rd_ptr];
    end
  end

endmodule

/* design/psum_deskew.sv */
module psum_deskew (
  input  logic                           clk,
  input  logic                           rst_n,
  input  gemm_pkg::sum_row_t             col_sum,
  input  logic [gemm_pkg::array_dim-1:0] col_valid,
  output gemm_pkg::sum_row_t             row_sum,
  output logic                           row_valid
);

  logic [gemm_pkg::array_dim-1:0] valid_aligned;

  // column c leaves the array c cycles late, so it waits 3 - c more
  for (genvar c = 0; c < gemm_pkg::array_dim; c++) begin : g_col
    if (c == gemm_pkg::array_dim - 1) begin : g_last
      assign row_sum[c] = col_sum[c];
      assign valid_aligned[c] = col_valid[c];
    end else begin : g_delay
      gemm_pkg::psum_t sum_pipe [gemm_pkg::array_dim-1-c];
      logic [gemm_pkg::array_dim-2-c:0] v_pipe;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          v_pipe <= '0;
        end else begin
          v_pipe[0] <= col_valid[c];
          for (int k = 1; k < gemm_pkg::array_dim - 1 - c; k++) begin
            v_pipe[k] <= v_pipe[k-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        sum_pipe[0] <= col_sum[c];
        for (int k = 1; k < gemm_pkg::array_dim - 1 - c; k++) begin
          sum_pipe[k] <= sum_pipe[k-1];
        end
      end

      assign row_sum[c] = sum_pipe[gemm_pkg::array_dim-2-c];
      assign valid_aligned[c] = v_pipe[gemm_pkg::array_dim-2-c];
    end
  end

  // all columns of one beat line up here
  assign row_valid = &valid_aligned;

endmodule

/* design/mac_array.sv */
module mac_array (
  input  logic                           clk,
  input  logic                           rst_n,
  input  gemm_pkg::act_vec_t             act_row,
  input  logic [gemm_pkg::array_dim-1:0] act_valid,
  input  gemm_pkg::wgt_vec_t             wgt_col,
  input  logic [gemm_pkg::array_dim-1:0] wgt_shift,
  input  logic [gemm_pkg::array_dim-1:0] wgt_commit,
  output gemm_pkg::sum_row_t             col_sum,
  output logic [gemm_pkg::array_dim-1:0] col_valid
);

  // activation links run [row][col], column array_dim is the right edge
  gemm_pkg::act_t act_link [gemm_pkg::array_dim][gemm_pkg::array_dim+1];
  logic act_v_link [gemm_pkg::array_dim][gemm_pkg::array_dim+1];

  // vertical links run [row][col], row array_dim is the bottom edge
  gemm_pkg::psum_t psum_link [gemm_pkg::array_dim+1][gemm_pkg::array_dim];
  gemm_pkg::wgt_t w_link [gemm_pkg::array_dim+1][gemm_pkg::array_dim];

  // shift and commit per row, rows 1 and below come from registers
  logic [gemm_pkg::array_dim-1:0] shift_q [gemm_pkg::array_dim-1];
  logic [gemm_pkg::array_dim-1:0] commit_q [gemm_pkg::array_dim-1];
  logic [gemm_pkg::array_dim-1:0] shift_row [gemm_pkg::array_dim];
  logic [gemm_pkg::array_dim-1:0] commit_row [gemm_pkg::array_dim];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < gemm_pkg::array_dim - 1; r++) begin
        shift_q[r] <= '0;
        commit_q[r] <= '0;
      end
    end else begin
      shift_q[0] <= wgt_shift;
      commit_q[0] <= wgt_commit;
      for (int r = 1; r < gemm_pkg::array_dim - 1; r++) begin
        shift_q[r] <= shift_q[r-1];
        commit_q[r] <= commit_q[r-1];
      end
    end
  end

  always_comb begin
    shift_row[0] = wgt_shift;
    commit_row[0] = wgt_commit;
    for (int r = 1; r < gemm_pkg::array_dim; r++) begin
      shift_row[r] = shift_q[r-1];
      commit_row[r] = commit_q[r-1];
    end
  end

  for (genvar r = 0; r < gemm_pkg::array_dim; r++) begin : g_left
    assign act_link[r][0] = act_row[r];
    assign act_v_link[r][0] = act_valid[r];
  end

  for (genvar c = 0; c < gemm_pkg::array_dim; c++) begin : g_edge
    assign psum_link[0][c] = '0;
    assign w_link[0][c] = wgt_col[c];
    assign col_sum[c] = psum_link[gemm_pkg::array_dim][c];
    // bottom cell's valid is registered with its psum
    assign col_valid[c] = act_v_link[gemm_pkg::array_dim-1][c+1];
  end

  for (genvar r = 0; r < gemm_pkg::array_dim; r++) begin : g_row
    for (genvar c = 0; c < gemm_pkg::array_dim; c++) begin : g_col
      mac_cell u_cell (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_in       (act_link[r][c]),
        .act_valid_in (act_v_link[r][c]),
        .psum_in      (psum_link[r][c]),
        .w_in         (w_link[r][c]),
        .w_shift      (shift_row[r][c]),
        .w_commit     (commit_row[r][c]),
        .act_out      (act_link[r][c+1]),
        .act_valid_out(act_v_link[r][c+1]),
        .psum_out     (psum_link[r+1][c]),
        .w_out        (w_link[r+1][c])
      );
    end
  end

endmodule

/* design/mac_cell.sv */
module mac_cell (
  input  logic              clk,
  input  logic              rst_n,
  input  gemm_pkg::act_t    act_in,
  input  logic              act_valid_in,
  input  gemm_pkg::psum_t   psum_in,
  input  gemm_pkg::wgt_t    w_in,
  input  logic              w_shift,
  input  logic              w_commit,
  output gemm_pkg::act_t    act_out,
  output logic              act_valid_out,
  output gemm_pkg::psum_t   psum_out,
  output gemm_pkg::wgt_t    w_out
);

  gemm_pkg::wgt_t  w_shadow;
  gemm_pkg::wgt_t  w_active;
  gemm_pkg::psum_t product;

  assign product = gemm_pkg::psum_t'(act_in) * gemm_pkg::psum_t'(w_active);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      act_valid_out <= 1'b0;
      w_active <= '0;
    end else begin
      act_valid_out <= act_valid_in;
      // commit beat also shifts, so take its incoming weight
      if (w_commit) begin
        w_active <= w_shift ? w_in : w_shadow;
      end
    end
  end

  always_ff @(posedge clk) begin
    act_out <= act_in;
    if (act_valid_in) begin
      psum_out <= psum_in + product;
    end else begin
      psum_out <= psum_in;
    end
    // hand the old shadow to the row below, which shifts one cycle later
    if (w_shift) begin
      w_shadow <= w_in;
      w_out <= w_shadow;
    end
  end

endmodule

/* design/operand_skew.sv */
module operand_skew (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_valid,
  input  gemm_pkg::in_beat_t             in_beat,
  output gemm_pkg::act_vec_t             act_row,
  output logic [gemm_pkg::array_dim-1:0] act_valid,
  output gemm_pkg::wgt_vec_t             wgt_col,
  output logic [gemm_pkg::array_dim-1:0] wgt_shift,
  output logic [gemm_pkg::array_dim-1:0] wgt_commit,
  output gemm_pkg::beat_ctrl_t           ctrl_aligned
);

  logic act_take;
  logic wgt_take;
  logic commit_take;
  gemm_pkg::beat_ctrl_t ctrl_in;
  gemm_pkg::beat_ctrl_t ctrl_pipe [gemm_pkg::pipe_lat-1];

  assign act_take = in_valid && !in_beat.is_wgt;
  assign wgt_take = in_valid && in_beat.is_wgt;
  assign commit_take = wgt_take && in_beat.commit;
  assign ctrl_in = '{valid: act_take, acc: in_beat.acc, last: in_beat.last};

  // lane i serves activation row i and weight column i, i+1 stages deep
  for (genvar i = 0; i < gemm_pkg::array_dim; i++) begin : g_lane
    gemm_pkg::act_t act_pipe [i+1];
    gemm_pkg::wgt_t wgt_pipe [i+1];
    logic [i:0] act_v_pipe;
    logic [i:0] shift_pipe;
    logic [i:0] commit_pipe;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        act_v_pipe <= '0;
        shift_pipe <= '0;
        commit_pipe <= '0;
      end else begin
        act_v_pipe[0] <= act_take;
        shift_pipe[0] <= wgt_take;
        commit_pipe[0] <= commit_take;
        for (int k = 1; k <= i; k++) begin
          act_v_pipe[k] <= act_v_pipe[k-1];
          shift_pipe[k] <= shift_pipe[k-1];
          commit_pipe[k] <= commit_pipe[k-1];
        end
      end
    end

    // same payload byte, read as row i or as column i
    always_ff @(posedge clk) begin
      act_pipe[0] <= in_beat.payload.act[i];
      wgt_pipe[0] <= in_beat.payload.wgt[i];
      for (int k = 1; k <= i; k++) begin
        act_pipe[k] <= act_pipe[k-1];
        wgt_pipe[k] <= wgt_pipe[k-1];
      end
    end

    assign act_row[i] = act_pipe[i];
    assign act_valid[i] = act_v_pipe[i];
    assign wgt_col[i] = wgt_pipe[i];
    assign wgt_shift[i] = shift_pipe[i];
    assign wgt_commit[i] = commit_pipe[i];
  end

  // flags ride alongside the array, land with the deskewed row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < gemm_pkg::pipe_lat - 1; k++) begin
        ctrl_pipe[k] <= '0;
      end
    end else begin
      ctrl_pipe[0] <= ctrl_in;
      for (int k = 1; k < gemm_pkg::pipe_lat - 1; k++) begin
        ctrl_pipe[k] <= ctrl_pipe[k-1];
      end
    end
  end

  assign ctrl_aligned = ctrl_pipe[gemm_pkg::pipe_lat-2];

endmodule

/* design/gemm_pkg.sv */
package gemm_pkg;

  localparam int array_dim = 4;
  localparam int a_bits = 8;
  localparam int w_bits = 8;
  localparam int p_bits = 24;

  // result fifo slots, also the upstream credit pool
  localparam int fifo_depth = 4;
  localparam int out_credits = 2;

  // accepted activation beat to accumulator update
  localparam int pipe_lat = 2 * array_dim + 1;

  localparam int ptr_bits = $clog2(fifo_depth);
  localparam int cnt_bits = $clog2(fifo_depth + 1);
  localparam int ocnt_bits = $clog2(out_credits + 1);

  typedef logic signed [a_bits-1:0] act_t;
  typedef logic signed [w_bits-1:0] wgt_t;
  typedef logic signed [p_bits-1:0] psum_t;

  // element i is array row i
  typedef act_t [array_dim-1:0] act_vec_t;
  // element i is array column i
  typedef wgt_t [array_dim-1:0] wgt_vec_t;
  typedef psum_t [array_dim-1:0] sum_row_t;

  typedef union packed {
    act_vec_t act;
    wgt_vec_t wgt;
  } beat_word_u;

  typedef struct packed {
    logic       is_wgt;
    logic       commit;
    logic       acc;
    logic       last;
    beat_word_u payload;
  } in_beat_t;

  typedef struct packed {
    logic valid;
    logic acc;
    logic last;
  } beat_ctrl_t;

  typedef logic [ptr_bits-1:0] ptr_t;
  typedef logic [cnt_bits-1:0] cnt_t;
  typedef logic [ocnt_bits-1:0] ocnt_t;

endpackage
